// ==== bench/core_assertions.sv ====
`timescale 1ns/1ps

module core_assertions import riscv_pkg::*; (
  input logic       clk,
  input logic       rst,
  input addr_t      mem_addr,
  input logic [3:0] mem_we
);

  // no write strobe leaves the core while it is held in reset
  no_write_in_reset: assert property (@(posedge clk) rst |=> (mem_we == 4'b0000))
    else $error("memory write strobe active during or right after reset");

  // first cycle out of reset fetches from the reset vector
  fetch_from_reset_pc: assert property (@(posedge clk)
    $fell(rst) |-> (mem_addr == reset_pc && mem_we == 4'b0000))
    else $error("first fetch after reset is not at the reset address");

  legal_byte_enables: assert property (@(posedge clk) disable iff (rst)
    mem_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
    else $error("byte enables form no byte, halfword or word pattern");

  // sb uses one lane, sh an aligned pair, sw all four
  lanes_follow_address: assert property (@(posedge clk) disable iff (rst)
    (mem_we != 4'b0000) |->
      (mem_we == (4'b0001 << mem_addr[1:0])) ||
      (mem_we == (4'b0011 << mem_addr[1:0]) && !mem_addr[0]) ||
      (mem_we == 4'b1111 && mem_addr[1:0] == 2'b00))
    else $error("byte enables do not match the low address bits");

  single_cycle_write: assert property (@(posedge clk) disable iff (rst)
    (mem_we != 4'b0000) |=> (mem_we == 4'b0000))
    else $error("write strobe held high for two cycles in a row");

endmodule

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb import riscv_pkg::*; ();

  localparam addr_t result_base = 32'h200;
  localparam addr_t load_base   = 32'h380;
  localparam addr_t part_base   = 32'h3c0;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  data_t      mem_rdata = '0;
  addr_t      mem_addr;
  data_t      mem_wdata;
  logic [3:0] mem_we;

  data_t      mem [256];
  int         prog_words = 0;
  int         st_off = 0;
  int         n_exp = 0;
  int         store_idx = 0;
  int         cycles = 0;
  int         cycle_limit = 0;
  string      exp_name [64];
  addr_t      exp_addr [64];
  logic [3:0] exp_we [64];
  data_t      exp_data [64];
  data_t      op_a;
  data_t      op_b;
  data_t      ld_word;
  logic [11:0] op_imm;
  logic [19:0] lui_imm;

  addr_t      exp_addr_cur;
  logic [3:0] exp_we_cur;
  data_t      exp_data_cur;
  data_t      lane_mask;
  logic       store_ok;

  multicycle_core uut (
    .clk       (clk),
    .rst       (rst),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we)
  );

  bind multicycle_core core_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .mem_addr (mem_addr),
    .mem_we   (mem_we)
  );

  always #2 clk = ~clk;

  // memory answers on the falling edge and the core samples on the rising one
  always @(negedge clk) begin
    mem_rdata = mem[mem_addr[9:2]];
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (!rst && mem_we != 4'b0000) begin
      for (int i = 0; i < 4; i++) begin
        if (mem_we[i]) begin
          mem[mem_addr[9:2]][8*i +: 8] = mem_wdata[8*i +: 8];
        end
      end
      store_idx = store_idx + 1;
    end
  end

  assign lane_mask    = {{8{mem_we[3]}}, {8{mem_we[2]}}, {8{mem_we[1]}}, {8{mem_we[0]}}};
  assign exp_addr_cur = (store_idx < n_exp) ? exp_addr[store_idx] : '1;
  assign exp_we_cur   = (store_idx < n_exp) ? exp_we[store_idx] : 4'b0000;
  assign exp_data_cur = (store_idx < n_exp) ? exp_data[store_idx] : '0;
  assign store_ok     = (mem_addr == exp_addr_cur) && (mem_we == exp_we_cur) &&
                        ((mem_wdata & lane_mask) == exp_data_cur);

  // outputs only move after a rising edge, so the falling edge sees them settled
  check_store: assert property (@(negedge clk) disable iff (rst)
    (mem_we != 4'b0000) |-> store_ok)
    else begin
      $display("MISMATCH test=%s expected addr=%h we=%b data=%h actual addr=%h we=%b data=%h",
               (store_idx < n_exp) ? exp_name[store_idx] : "extra store",
               exp_addr_cur, exp_we_cur, exp_data_cur, mem_addr, mem_we,
               mem_wdata & lane_mask);
      $display("TEST FAILED");
      $fatal(1, "store did not match the expected sequence");
    end

  function automatic instr_t rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic instr_t itype(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t stype(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic instr_t btype(input logic [12:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic instr_t jtype(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  function automatic instr_t utype(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opc_lui};
  endfunction

  task automatic emit(input instr_t ins);
    mem[prog_words] = ins;
    prog_words++;
  endtask

  task automatic expect_store(input string name, input addr_t addr, input logic [3:0] we,
                              input data_t data);
    data_t mask;
    mask = {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
    exp_name[n_exp] = name;
    exp_addr[n_exp] = addr;
    exp_we[n_exp]   = we;
    exp_data[n_exp] = data & mask;
    n_exp++;
  endtask

  // sw into the next free word of the result area based at x3
  task automatic store_result(input string name, input logic [4:0] rs, input data_t value);
    emit(stype(12'(st_off), rs, 5'd3, 3'b010));
    expect_store(name, result_base + addr_t'(st_off), 4'b1111, value);
    st_off += 4;
  endtask

  // lui then addi with the upper part rounded up for a negative low part
  task automatic load_const(input logic [4:0] rd, input data_t value);
    data_t upper;
    upper = value + 32'h800;
    emit(utype(upper[31:12], rd));
    emit(itype(value[11:0], rd, 3'b000, rd, opc_op_imm));
  endtask

  task automatic r_op_case(input string name, input logic [2:0] f3, input logic [6:0] f7,
                           input data_t value);
    emit(rtype(f7, 5'd2, 5'd1, f3, 5'd4));
    store_result(name, 5'd4, value);
  endtask

  task automatic i_op_case(input string name, input logic [2:0] f3, input data_t value);
    emit(itype(op_imm, 5'd1, f3, 5'd4, opc_op_imm));
    store_result(name, 5'd4, value);
  endtask

  initial begin
    int         k;
    logic [7:0]  lane;
    logic [15:0] half;
    data_t      imm_x;
    addr_t      jal_pc;

    void'($urandom(8));
    for (k = 0; k < 256; k++) begin
      mem[k] = ~(32'(k) << 2);
    end
    op_a    = $urandom();
    // never equal to op_a so that branches on x1 and x2 see a nonzero difference
    op_b    = op_a ^ ($urandom() | 32'd1);
    op_imm  = 12'($urandom());
    lui_imm = 20'($urandom());
    ld_word = $urandom();
    imm_x   = {{20{op_imm[11]}}, op_imm};
    mem[load_base / 4] = ld_word;

    load_const(5'd1, op_a);
    load_const(5'd2, op_b);
    emit(itype(12'(result_base), 5'd0, 3'b000, 5'd3, opc_op_imm));

    r_op_case("add", 3'b000, 7'h00, op_a + op_b);
    r_op_case("sub", 3'b000, 7'h20, op_a - op_b);
    r_op_case("and", 3'b111, 7'h00, op_a & op_b);
    r_op_case("or",  3'b110, 7'h00, op_a | op_b);
    r_op_case("xor", 3'b100, 7'h00, op_a ^ op_b);
    r_op_case("slt", 3'b010, 7'h00, {31'b0, $signed(op_a) < $signed(op_b)});
    r_op_case("sll", 3'b001, 7'h00, op_a << op_b[4:0]);
    r_op_case("srl", 3'b101, 7'h00, op_a >> op_b[4:0]);

    i_op_case("addi", 3'b000, op_a + imm_x);
    i_op_case("slti", 3'b010, {31'b0, $signed(op_a) < $signed(imm_x)});
    i_op_case("xori", 3'b100, op_a ^ imm_x);
    i_op_case("ori",  3'b110, op_a | imm_x);
    i_op_case("andi", 3'b111, op_a & imm_x);

    emit(utype(lui_imm, 5'd4));
    store_result("lui", 5'd4, {lui_imm, 12'b0});

    // loads from every lane of the word at x5
    emit(itype(12'(load_base), 5'd0, 3'b000, 5'd5, opc_op_imm));
    for (k = 0; k < 4; k++) begin
      lane = ld_word[8*k +: 8];
      emit(itype(12'(k), 5'd5, 3'b000, 5'd4, opc_load));
      store_result($sformatf("lb offset %0d", k), 5'd4, {{24{lane[7]}}, lane});
      emit(itype(12'(k), 5'd5, 3'b100, 5'd4, opc_load));
      store_result($sformatf("lbu offset %0d", k), 5'd4, {24'b0, lane});
    end
    for (k = 0; k < 4; k += 2) begin
      half = ld_word[8*k +: 16];
      emit(itype(12'(k), 5'd5, 3'b001, 5'd4, opc_load));
      store_result($sformatf("lh offset %0d", k), 5'd4, {{16{half[15]}}, half});
      emit(itype(12'(k), 5'd5, 3'b101, 5'd4, opc_load));
      store_result($sformatf("lhu offset %0d", k), 5'd4, {16'b0, half});
    end
    emit(itype(12'd0, 5'd5, 3'b010, 5'd4, opc_load));
    store_result("lw", 5'd4, ld_word);

    emit(itype(12'(part_base), 5'd0, 3'b000, 5'd7, opc_op_imm));
    for (k = 0; k < 4; k++) begin
      emit(stype(12'(k), 5'd1, 5'd7, 3'b000));
      expect_store($sformatf("sb lane %0d", k), part_base + addr_t'(k), 4'b0001 << k,
                   data_t'(op_a[7:0]) << (8 * k));
    end
    for (k = 0; k < 4; k += 2) begin
      emit(stype(12'(4 + k), 5'd1, 5'd7, 3'b001));
      expect_store($sformatf("sh lane %0d", k), part_base + addr_t'(4 + k),
                   (k == 0) ? 4'b0011 : 4'b1100, data_t'(op_a[15:0]) << (8 * k));
    end

    // taken beq jumps over a store of x0
    emit(btype(13'd8, 5'd1, 5'd1, 3'b000));
    emit(stype(12'(st_off), 5'd0, 5'd3, 3'b010));
    store_result("beq taken", 5'd2, op_b);
    emit(btype(13'd8, 5'd1, 5'd1, 3'b001));
    store_result("bne not taken", 5'd1, op_a);
    // x1 and x2 differ, so here the compare result decides
    emit(btype(13'd8, 5'd2, 5'd1, 3'b000));
    store_result("beq not taken", 5'd1, op_a);
    emit(btype(13'd8, 5'd2, 5'd1, 3'b001));
    emit(stype(12'(st_off), 5'd0, 5'd3, 3'b010));
    store_result("bne taken", 5'd2, op_b);
    jal_pc = addr_t'(prog_words * 4);
    emit(jtype(21'd8, 5'd6));
    emit(stype(12'(st_off), 5'd0, 5'd3, 3'b010));
    store_result("jal link", 5'd6, jal_pc + 32'd4);
    // park the core in a loop without stores
    emit(jtype(21'd0, 5'd0));

    // five cycles per instruction at most and five times that as margin
    cycle_limit = 25 * prog_words;

    repeat (8) @(negedge clk);
    rst = 1'b0;

    while (store_idx < n_exp && cycles < cycle_limit) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);

    if (store_idx == n_exp) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "timeout after %0d cycles with %0d of %0d stores seen",
             cycles, store_idx, n_exp);
    end
  end

endmodule

// ==== multicycle_core.f ====
src/riscv_pkg.sv
src/ctrl_if.sv
src/control_fsm.sv
src/pc_fetch.sv
src/instr_decode.sv
src/reg_file.sv
src/alu.sv
src/mem_loader.sv
src/multicycle_core.sv
bench/core_assertions.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
  -f multicycle_core.f --Mdir "$build_dir" -o core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/core_sim" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import riscv_pkg::*; (
  input  data_t   a,
  input  data_t   b,
  input  alu_op_t op,
  output data_t   result,
  output logic    zero
);

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_slt:    result = data_t'($signed(a) < $signed(b));
      // shift amount is the low five bits only
      alu_sll:    result = a << b[4:0];
      alu_srl:    result = a >> b[4:0];
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // beq and bne look at this after a sub
  assign zero = (result == '0);

endmodule

// ==== src/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm import riscv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  opcode_t    opcode,
  input  logic [2:0] funct3,
  input  logic       zero_flag,
  input  logic [1:0] addr_low,
  ctrl_if.fsm        ctrl,
  output logic [3:0] byte_en
);

  fsm_state_t state;
  fsm_state_t state_next;
  logic       branch_taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = st_fetch;
    case (state)
      st_fetch: state_next = st_decode;
      st_decode: begin
        case (opcode)
          opc_load, opc_store: state_next = st_mem_adr;
          opc_op:              state_next = st_exec_r;
          opc_op_imm:          state_next = st_exec_i;
          opc_branch:          state_next = st_branch;
          opc_jal:             state_next = st_jal;
          opc_lui:             state_next = st_lui;
          // unsupported opcodes are skipped
          default:             state_next = st_fetch;
        endcase
      end
      st_mem_adr:  state_next = (opcode == opc_load) ? st_mem_read : st_mem_write;
      st_mem_read: state_next = st_mem_wb;
      st_exec_r:   state_next = st_alu_wb;
      st_exec_i:   state_next = st_alu_wb;
      st_jal:      state_next = st_alu_wb;
      default:     state_next = st_fetch;
    endcase
  end

  // beq takes on zero, bne on nonzero
  assign branch_taken = zero_flag ^ funct3[0];

  assign ctrl.pc_update   = (state == st_fetch) || (state == st_jal) ||
                            ((state == st_branch) && branch_taken);
  assign ctrl.pc_src_jump = (state == st_jal) || (state == st_branch);

  always_comb begin
    ctrl.ir_write       = 1'b0;
    ctrl.reg_write      = 1'b0;
    ctrl.mem_write      = 1'b0;
    ctrl.alu_src_a      = src_a_pc;
    ctrl.alu_src_b      = src_b_four;
    ctrl.alu_op_sel_imm = 1'b0;
    ctrl.result_src     = res_alu_out;
    ctrl.adr_src        = adr_pc;
    case (state)
      st_fetch: begin
        ctrl.ir_write = 1'b1;
      end
      st_decode: begin
        // branch and jump target into alu_out
        ctrl.alu_src_a = src_a_old_pc;
        ctrl.alu_src_b = src_b_imm;
      end
      st_mem_adr: begin
        ctrl.alu_src_a = src_a_rs1;
        ctrl.alu_src_b = src_b_imm;
      end
      st_mem_read: begin
        ctrl.adr_src = adr_result;
      end
      st_mem_wb: begin
        ctrl.reg_write  = 1'b1;
        ctrl.result_src = res_data;
      end
      st_mem_write: begin
        ctrl.adr_src   = adr_result;
        ctrl.mem_write = 1'b1;
      end
      st_exec_r, st_branch: begin
        ctrl.alu_src_a      = src_a_rs1;
        ctrl.alu_src_b      = src_b_rs2;
        ctrl.alu_op_sel_imm = 1'b1;
      end
      st_exec_i: begin
        ctrl.alu_src_a      = src_a_rs1;
        ctrl.alu_src_b      = src_b_imm;
        ctrl.alu_op_sel_imm = 1'b1;
      end
      st_alu_wb: begin
        ctrl.reg_write = 1'b1;
      end
      st_jal: begin
        // link address, written back in alu_wb
        ctrl.alu_src_a = src_a_old_pc;
      end
      st_lui: begin
        ctrl.alu_src_a      = src_a_zero;
        ctrl.alu_src_b      = src_b_imm;
        ctrl.alu_op_sel_imm = 1'b1;
        ctrl.result_src     = res_alu_result;
        ctrl.reg_write      = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // lane mask of the store, the datapath gates it with mem_write
  always_comb begin
    case (funct3[1:0])
      2'b00:   byte_en = 4'b0001 << addr_low;
      2'b01:   byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
      default: byte_en = 4'b1111;
    endcase
  end

endmodule

// ==== src/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if import riscv_pkg::*; ();

  logic        pc_update;
  logic        pc_src_jump;
  logic        ir_write;
  logic        reg_write;
  logic        mem_write;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  // high: ALU runs the op decoded from the instruction, low: forced add
  logic        alu_op_sel_imm;
  result_src_t result_src;
  adr_src_t    adr_src;

  modport fsm (
    output pc_update, pc_src_jump, ir_write, reg_write, mem_write,
    output alu_src_a, alu_src_b, alu_op_sel_imm, result_src, adr_src
  );

  modport datapath (
    input pc_update, pc_src_jump, ir_write, reg_write, mem_write,
    input alu_src_a, alu_src_b, alu_op_sel_imm, result_src, adr_src
  );

endinterface

// ==== src/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode import riscv_pkg::*; (
  input  instr_t     instr,
  output opcode_t    opcode,
  output logic [2:0] funct3,
  output logic [4:0] rd,
  output logic [4:0] rs1,
  output logic [4:0] rs2,
  output data_t      imm_ext,
  output alu_op_t    alu_op
);

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    case (opcode)
      opc_store:  imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      opc_branch: imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      opc_jal:    imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      opc_lui:    imm_ext = {instr[31:12], 12'b0};
      default:    imm_ext = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  always_comb begin
    alu_op = alu_add;
    case (opcode)
      opc_op, opc_op_imm: begin
        case (funct3)
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = alu_srl;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: alu_op = alu_add;
        endcase
        // funct7 bit 5 selects sub, only for register operands
        if (opcode == opc_op && funct3 == 3'b000 && instr[30]) begin
          alu_op = alu_sub;
        end
      end
      opc_branch: alu_op = alu_sub;
      opc_lui:    alu_op = alu_pass_b;
      default:    alu_op = alu_add;
    endcase
  end

endmodule

// ==== src/mem_loader.sv ====
`timescale 1ns/1ps

module mem_loader import riscv_pkg::*; (
  input  data_t      rdata,
  input  logic [1:0] addr_low,
  input  logic [2:0] funct3,
  input  data_t      store_src,
  output data_t      load_value,
  output data_t      wdata
);

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  assign lane_byte = rdata[8*addr_low +: 8];
  assign lane_half = addr_low[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3)
      3'b000:  load_value = {{24{lane_byte[7]}}, lane_byte};
      3'b001:  load_value = {{16{lane_half[15]}}, lane_half};
      3'b100:  load_value = {24'b0, lane_byte};
      3'b101:  load_value = {16'b0, lane_half};
      default: load_value = rdata;
    endcase
  end

  // copy the value to every lane, byte enables pick the one written
  always_comb begin
    case (funct3[1:0])
      2'b00:   wdata = {4{store_src[7:0]}};
      2'b01:   wdata = {2{store_src[15:0]}};
      default: wdata = store_src;
    endcase
  end

endmodule

// ==== src/multicycle_core.sv ====
`timescale 1ns/1ps

module multicycle_core import riscv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  data_t      mem_rdata,
  output addr_t      mem_addr,
  output data_t      mem_wdata,
  output logic [3:0] mem_we
);

  ctrl_if ctrl ();

  instr_t     instr;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  data_t      imm_ext;
  alu_op_t    dec_alu_op;
  alu_op_t    alu_op;

  addr_t pc_cur;
  addr_t pc_old;
  data_t rdata1;
  data_t rdata2;
  data_t rs1_q;
  data_t rs2_q;
  data_t load_value;
  data_t data_q;
  data_t alu_a;
  data_t alu_b;
  data_t alu_result;
  data_t alu_out;
  data_t result;
  logic  zero_flag;
  logic [3:0] byte_en;

  control_fsm u_fsm (
    .clk       (clk),
    .rst       (rst),
    .opcode    (opcode),
    .funct3    (funct3),
    .zero_flag (zero_flag),
    .addr_low  (mem_addr[1:0]),
    .ctrl      (ctrl),
    .byte_en   (byte_en)
  );

  pc_fetch u_pc (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .alu_out (alu_out),
    .pc_cur  (pc_cur),
    .pc_old  (pc_old)
  );

  instr_decode u_dec (
    .instr   (instr),
    .opcode  (opcode),
    .funct3  (funct3),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .imm_ext (imm_ext),
    .alu_op  (dec_alu_op)
  );

  reg_file u_rf (
    .clk    (clk),
    .rst    (rst),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .we     (ctrl.reg_write),
    .wdata  (result),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result),
    .zero   (zero_flag)
  );

  mem_loader u_ld (
    .rdata      (mem_rdata),
    .addr_low   (mem_addr[1:0]),
    .funct3     (funct3),
    .store_src  (rs2_q),
    .load_value (load_value),
    .wdata      (mem_wdata)
  );

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      instr <= mem_rdata;
    end
  end

  // datapath pipeline registers, loaded every cycle
  always_ff @(posedge clk) begin
    rs1_q   <= rdata1;
    rs2_q   <= rdata2;
    data_q  <= load_value;
    alu_out <= alu_result;
  end

  assign alu_op = ctrl.alu_op_sel_imm ? dec_alu_op : alu_add;

  always_comb begin
    case (ctrl.alu_src_a)
      src_a_pc:     alu_a = pc_cur;
      src_a_old_pc: alu_a = pc_old;
      src_a_rs1:    alu_a = rs1_q;
      default:      alu_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_src_b)
      src_b_rs2: alu_b = rs2_q;
      src_b_imm: alu_b = imm_ext;
      default:   alu_b = data_t'(4);
    endcase
  end

  always_comb begin
    case (ctrl.result_src)
      res_data:       result = data_q;
      res_alu_result: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  assign mem_addr = (ctrl.adr_src == adr_pc) ? pc_cur : result;
  assign mem_we   = ctrl.mem_write ? byte_en : 4'b0000;

endmodule

// ==== src/pc_fetch.sv ====
`timescale 1ns/1ps

module pc_fetch import riscv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  ctrl_if.datapath ctrl,
  input  addr_t alu_out,
  output addr_t pc_cur,
  output addr_t pc_old
);

  addr_t pc_next;

  // jumps and taken branches use the target held in alu_out
  assign pc_next = ctrl.pc_src_jump ? alu_out : pc_cur + addr_t'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_cur <= reset_pc;
    end else if (ctrl.pc_update) begin
      pc_cur <= pc_next;
    end
  end

  // address of the instruction now in the instruction register
  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      pc_old <= pc_cur;
    end
  end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import riscv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [4:0] rs1,
  input  logic [4:0] rs2,
  input  logic [4:0] rd,
  input  logic       we,
  input  data_t      wdata,
  output data_t      rdata1,
  output data_t      rdata2
);

  data_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== src/riscv_pkg.sv ====
package riscv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] data_t;
  typedef logic [xlen-1:0] addr_t;
  typedef logic [31:0]     instr_t;

  // first instruction fetched after reset
  localparam addr_t reset_pc = '0;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_lui    = 7'b0110111
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rs1, src_a_zero} alu_src_a_t;
  typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} alu_src_b_t;
  typedef enum logic [1:0] {res_alu_out, res_data, res_alu_result} result_src_t;
  typedef enum logic {adr_pc, adr_result} adr_src_t;

  typedef enum logic [3:0] {
    st_fetch,
    st_decode,
    st_mem_adr,
    st_mem_read,
    st_mem_wb,
    st_mem_write,
    st_exec_r,
    st_exec_i,
    st_alu_wb,
    st_branch,
    st_jal,
    st_lui
  } fsm_state_t;

endpackage
